// File: cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath widths
`define DBITS          32
`define INST_BITS      32
`define REGNO_BITS     4
`define IMM_BITS       16
`define INST_SIZE      32'd4   // Bytes per instruction

// Word index widths of the two memories
`define IMEM_WORD_BITS 10
`define DMEM_WORD_BITS 10

// First fetch address after reset
`define START_PC       32'h0000_0100

// Memory-mapped I/O
`define ADDR_HEX       32'hFFFF_F000
`define ADDR_LEDR      32'hFFFF_F020
`define ADDR_KEY       32'hFFFF_F080

// I/O widths
`define HEX_BITS       24
`define LEDR_BITS      10
`define KEY_BITS       4

`define HEX_RESET      24'hFEDEAD   // Display value out of reset

`endif

// File: cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

  typedef logic [`DBITS-1:0]          word_t;
  typedef logic [`INST_BITS-1:0]      inst_t;
  typedef logic [`REGNO_BITS-1:0]     regno_t;
  typedef logic [`IMEM_WORD_BITS-1:0] imem_addr_t;
  typedef logic [`HEX_BITS-1:0]       hex_t;
  typedef logic [`LEDR_BITS-1:0]      ledr_t;
  typedef logic [`KEY_BITS-1:0]       key_t;

  // Primary opcode in bits 31..26
  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_e;

  // Secondary opcode of ALUR in bits 25..18
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_e;

  typedef struct packed {
    logic is_br;
    logic is_jmp;
    logic rd_mem;
    logic wr_mem;
    logic wr_reg;
  } ctrl_t;

  // --------------------------------------------------
  // Stage latches
  // --------------------------------------------------
  typedef struct packed {
    inst_t inst;
    word_t pc_next;
  } fe_id_t;

  typedef struct packed {
    op1_e   op1;
    op2_e   op2;
    word_t  pc_next;
    word_t  regval1;
    word_t  regval2;
    word_t  immval;   // Sign-extended
    regno_t wregno;
    ctrl_t  ctrl;
  } id_ex_t;

  typedef struct packed {
    word_t  aluout;   // Also the memory address
    word_t  regval2;  // Store data
    regno_t wregno;
    logic   rd_mem;
    logic   wr_mem;
    logic   wr_reg;
  } ex_mem_t;

  typedef struct packed {
    logic   wr_reg;
    regno_t wregno;
    word_t  value;
  } wb_t;

  typedef struct packed {
    logic  mispred;
    word_t pc_good;
  } redirect_t;

endpackage

// File: fetch_stage.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module fetch_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                prog_we,
  input  cpu_pkg::imem_addr_t prog_addr,
  input  cpu_pkg::inst_t      prog_data,
  input  logic                stall,
  input  cpu_pkg::redirect_t  redirect,
  output cpu_pkg::fe_id_t     fe_id
);

  import cpu_pkg::*;

  localparam int IMEM_WORDS = 1 << `IMEM_WORD_BITS;

  word_t      pc;
  word_t      pc_next;
  imem_addr_t fetch_idx;
  inst_t      imem [IMEM_WORDS];

  assign pc_next   = pc + `INST_SIZE;
  assign fetch_idx = pc[`IMEM_WORD_BITS+1:2]; // Drop byte offset

  // Program load port
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= `START_PC;
    end else if (redirect.mispred) begin
      pc <= redirect.pc_good;
    end else if (!stall) begin
      pc <= pc_next;
    end
  end

  // Fetch latch is flushed on redirect and held on stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fe_id <= '0;
    end else if (redirect.mispred) begin
      fe_id <= '0;
    end else if (!stall) begin
      fe_id.inst    <= imem[fetch_idx];
      fe_id.pc_next <= pc_next;
    end
  end

  // JAL targets come from a register and may be anything
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

// File: decode_stage.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module decode_stage (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::fe_id_t    fe_id,
  input  cpu_pkg::wb_t       wb,
  input  cpu_pkg::id_ex_t    id_ex_q,
  input  cpu_pkg::ex_mem_t   ex_mem_q,
  input  cpu_pkg::redirect_t redirect,
  output logic               stall,
  output cpu_pkg::id_ex_t    id_ex
);

  import cpu_pkg::*;

  localparam int REG_COUNT = 1 << `REGNO_BITS;

  op1_e                 op1;
  op2_e                 op2;
  logic [`IMM_BITS-1:0] imm;
  regno_t               rd;
  regno_t               rs;
  regno_t               rt;
  word_t                regs [REG_COUNT];
  word_t                regval1;
  word_t                regval2;
  logic                 op2_valid;
  logic                 rt_src;     // rt is read as an operand
  ctrl_t                ctrl;
  regno_t               wregno;
  id_ex_t               id_ex_d;

  function automatic logic dep_hit(input logic wr, input regno_t wno, input regno_t src1,
                                   input regno_t src2, input logic src2_used);
    dep_hit = wr && ((wno == src1) || (src2_used && (wno == src2)));
  endfunction

  // --------------------------------------------------
  // Field split and register read
  // --------------------------------------------------
  assign op1 = op1_e'(fe_id.inst[31:26]);
  assign op2 = op2_e'(fe_id.inst[25:18]);
  assign imm = fe_id.inst[23:8];
  assign rd  = fe_id.inst[11:8];
  assign rs  = fe_id.inst[7:4];
  assign rt  = fe_id.inst[3:0];

  // Same-cycle write shows through
  assign regval1 = (wb.wr_reg && (wb.wregno == rs)) ? wb.value : regs[rs];
  assign regval2 = (wb.wr_reg && (wb.wregno == rt)) ? wb.value : regs[rt];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wr_reg) begin
      regs[wb.wregno] <= wb.value;
    end
  end

  // --------------------------------------------------
  // Control bits
  // --------------------------------------------------
  // Unknown ALUR functions act as a no-op, so an all-zero bubble writes nothing
  assign op2_valid = op2 inside {OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND, OP2_OR,
                                 OP2_XOR, OP2_SUB, OP2_NAND, OP2_NOR, OP2_NXOR, OP2_RSHF,
                                 OP2_LSHF};

  always_comb begin
    ctrl   = '0;
    rt_src = 1'b0;
    case (op1)
      OP1_ALUR: begin
        ctrl.wr_reg = op2_valid;
        rt_src      = 1'b1;
      end
      OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE: begin
        ctrl.is_br = 1'b1;
        rt_src     = 1'b1;
      end
      OP1_JAL: begin
        ctrl.is_jmp = 1'b1;
        ctrl.wr_reg = 1'b1;  // Link into rt
      end
      OP1_LW: begin
        ctrl.rd_mem = 1'b1;
        ctrl.wr_reg = 1'b1;
      end
      OP1_SW: begin
        ctrl.wr_mem = 1'b1;
        rt_src      = 1'b1;  // Store data
      end
      OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI: begin
        ctrl.wr_reg = 1'b1;
      end
      default: ;
    endcase
  end

  assign wregno = (op1 == OP1_ALUR) ? rd : rt;

  // Only EX and MEM can stall since WB reads through
  assign stall = dep_hit(id_ex_q.ctrl.wr_reg, id_ex_q.wregno, rs, rt, rt_src) ||
                 dep_hit(ex_mem_q.wr_reg, ex_mem_q.wregno, rs, rt, rt_src);

  always_comb begin
    id_ex_d.op1     = op1;
    id_ex_d.op2     = op2;
    id_ex_d.pc_next = fe_id.pc_next;
    id_ex_d.regval1 = regval1;
    id_ex_d.regval2 = regval2;
    id_ex_d.immval  = {{(`DBITS-`IMM_BITS){imm[`IMM_BITS-1]}}, imm};
    id_ex_d.wregno  = wregno;
    id_ex_d.ctrl    = ctrl;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_ex <= '0;
    end else if (redirect.mispred || stall) begin
      id_ex <= '0;   // Bubble
    end else begin
      id_ex <= id_ex_d;
    end
  end

  // A flushed fetch latch decodes to an ALUR no-op
  a_bubble_no_write: assert property (@(posedge clk) disable iff (reset)
    (fe_id.inst == '0) |-> !ctrl.wr_reg);

endmodule

// File: execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::id_ex_t    id_ex,
  output cpu_pkg::redirect_t redirect,
  output cpu_pkg::ex_mem_t   ex_mem
);

  import cpu_pkg::*;

  word_t   a;
  word_t   b;
  word_t   imm;
  word_t   aluout;
  logic    br_cond;
  logic    taken;
  word_t   target_base;
  word_t   target;
  ex_mem_t ex_mem_d;

  assign a   = id_ex.regval1;
  assign b   = id_ex.regval2;
  assign imm = id_ex.immval;

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  always_comb begin
    aluout = '0;
    case (id_ex.op1)
      OP1_ALUR: begin
        case (id_ex.op2)
          OP2_EQ:   aluout = word_t'(a == b);
          OP2_LT:   aluout = word_t'($signed(a) < $signed(b));
          OP2_LE:   aluout = word_t'($signed(a) <= $signed(b));
          OP2_NE:   aluout = word_t'(a != b);
          OP2_ADD:  aluout = a + b;
          OP2_AND:  aluout = a & b;
          OP2_OR:   aluout = a | b;
          OP2_XOR:  aluout = a ^ b;
          OP2_SUB:  aluout = a - b;
          OP2_NAND: aluout = ~(a & b);
          OP2_NOR:  aluout = ~(a | b);
          OP2_NXOR: aluout = ~(a ^ b);
          OP2_RSHF: aluout = word_t'($signed(a) >>> b);  // Arithmetic
          OP2_LSHF: aluout = a << b;
          default:  aluout = '0;
        endcase
      end
      OP1_ADDI, OP1_LW, OP1_SW: aluout = a + imm;  // Address for memory ops
      OP1_ANDI: aluout = a & imm;
      OP1_ORI:  aluout = a | imm;
      OP1_XORI: aluout = a ^ imm;
      OP1_JAL:  aluout = id_ex.pc_next;   // Return address
      default:  aluout = '0;
    endcase
  end

  // Branch condition uses signed compares
  always_comb begin
    case (id_ex.op1)
      OP1_BEQ: br_cond = (a == b);
      OP1_BLT: br_cond = ($signed(a) < $signed(b));
      OP1_BLE: br_cond = ($signed(a) <= $signed(b));
      OP1_BNE: br_cond = (a != b);
      default: br_cond = 1'b0;
    endcase
  end

  assign taken       = id_ex.ctrl.is_jmp || (id_ex.ctrl.is_br && br_cond);
  assign target_base = id_ex.ctrl.is_jmp ? a : id_ex.pc_next;
  assign target      = target_base + (imm << 2);

  always_comb begin
    ex_mem_d.aluout  = aluout;
    ex_mem_d.regval2 = b;
    ex_mem_d.wregno  = id_ex.wregno;
    ex_mem_d.rd_mem  = id_ex.ctrl.rd_mem;
    ex_mem_d.wr_mem  = id_ex.ctrl.wr_mem;
    ex_mem_d.wr_reg  = id_ex.ctrl.wr_reg;
  end

  // --------------------------------------------------
  // Execute latch and redirect
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_mem   <= '0;
      redirect <= '0;
    end else if (redirect.mispred) begin
      ex_mem   <= '0;   // Wrong-path instruction
      redirect <= '0;
    end else begin
      ex_mem           <= ex_mem_d;
      redirect.mispred <= taken;
      redirect.pc_good <= target;
    end
  end

endmodule

// File: memory_stage.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module memory_stage (
  input  logic             clk,
  input  logic             reset,
  input  cpu_pkg::ex_mem_t ex_mem,
  input  cpu_pkg::key_t    key,
  output cpu_pkg::wb_t     wb,
  output cpu_pkg::hex_t    hex,
  output cpu_pkg::ledr_t   ledr
);

  import cpu_pkg::*;

  localparam int DMEM_WORDS = 1 << `DMEM_WORD_BITS;

  word_t                      dmem [DMEM_WORDS];
  logic [`DMEM_WORD_BITS-1:0] dmem_idx;
  logic                       sel_hex;
  logic                       sel_ledr;
  logic                       sel_key;
  word_t                      load_val;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  assign dmem_idx = ex_mem.aluout[`DMEM_WORD_BITS+1:2];
  assign sel_hex  = (ex_mem.aluout == `ADDR_HEX);
  assign sel_ledr = (ex_mem.aluout == `ADDR_LEDR);
  assign sel_key  = (ex_mem.aluout == `ADDR_KEY);

  // Keys are active low on the pins
  assign load_val = sel_key ? {{(`DBITS-`KEY_BITS){1'b0}}, ~key} : dmem[dmem_idx];

  always_ff @(posedge clk) begin
    if (ex_mem.wr_mem && !sel_hex && !sel_ledr) begin
      dmem[dmem_idx] <= ex_mem.regval2;
    end
  end

  // Output registers
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex  <= `HEX_RESET;
      ledr <= '0;
    end else if (ex_mem.wr_mem) begin
      if (sel_hex) begin
        hex <= ex_mem.regval2[`HEX_BITS-1:0];
      end
      if (sel_ledr) begin
        ledr <= ex_mem.regval2[`LEDR_BITS-1:0];
      end
    end
  end

  // Write-back latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb.wr_reg <= ex_mem.wr_reg;
      wb.wregno <= ex_mem.wregno;
      wb.value  <= ex_mem.rd_mem ? load_val : ex_mem.aluout;
    end
  end

  a_ld_st_excl: assert property (@(posedge clk) disable iff (reset)
    !(ex_mem.rd_mem && ex_mem.wr_mem));

endmodule

// File: cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                prog_we,
  input  cpu_pkg::imem_addr_t prog_addr,
  input  cpu_pkg::inst_t      prog_data,
  input  cpu_pkg::key_t       key,
  output cpu_pkg::hex_t       hex,
  output cpu_pkg::ledr_t      ledr
);

  import cpu_pkg::*;

  fe_id_t    fe_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  wb_t       wb;
  redirect_t redirect;
  logic      stall;

  fetch_stage fetch_i (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .stall     (stall),
    .redirect  (redirect),
    .fe_id     (fe_id)
  );

  decode_stage decode_i (
    .clk      (clk),
    .reset    (reset),
    .fe_id    (fe_id),
    .wb       (wb),
    .id_ex_q  (id_ex),    // Own latch for the hazard check
    .ex_mem_q (ex_mem),
    .redirect (redirect),
    .stall    (stall),
    .id_ex    (id_ex)
  );

  execute_stage execute_i (
    .clk      (clk),
    .reset    (reset),
    .id_ex    (id_ex),
    .redirect (redirect),
    .ex_mem   (ex_mem)
  );

  memory_stage memory_i (
    .clk    (clk),
    .reset  (reset),
    .ex_mem (ex_mem),
    .key    (key),
    .wb     (wb),
    .hex    (hex),
    .ledr   (ledr)
  );

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module tb_cpu;

  import cpu_pkg::*;

  localparam word_t HEX_ADDR    = `ADDR_HEX;
  localparam word_t LEDR_OFFSET = `ADDR_LEDR - `ADDR_HEX;
  localparam word_t KEY_OFFSET  = `ADDR_KEY - `ADDR_HEX;
  localparam int    WAIT_LIMIT  = 300;   // Cycles allowed per program

  logic       clk;
  logic       reset;
  logic       prog_we;
  imem_addr_t prog_addr;
  inst_t      prog_data;
  key_t       key;
  hex_t       hex;
  ledr_t      ledr;

  inst_t       prog [$];
  logic [15:0] lfsr_state = 16'd25314;

  op2_e alu_ops [14] = '{OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND, OP2_OR,
                         OP2_XOR, OP2_SUB, OP2_NAND, OP2_NOR, OP2_NXOR, OP2_RSHF, OP2_LSHF};
  op1_e imm_ops [4] = '{OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};
  op1_e br_ops [4]  = '{OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE};
  logic [15:0] br_a [3] = '{16'hFFFB, 16'd7, 16'd3};   // -5, 7, 3
  logic [15:0] br_b [3] = '{16'd3, 16'd7, 16'hFFFB};

  cpu_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .key       (key),
    .hex       (hex),
    .ledr      (ledr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // Encoders, LFSR and reference model
  // --------------------------------------------------
  function automatic inst_t enc_r(input op2_e op2, input regno_t rd, input regno_t rs,
                                  input regno_t rt);
    enc_r = {OP1_ALUR, op2, 6'b000000, rd, rs, rt};
  endfunction

  function automatic inst_t enc_i(input op1_e op1, input regno_t rt, input regno_t rs,
                                  input logic [15:0] imm);
    enc_i = {op1, 2'b00, imm, rs, rt};
  endfunction

  function automatic word_t sext(input logic [15:0] v);
    sext = {{16{v[15]}}, v};
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    rand_bits = r;
  endfunction

  function automatic word_t alu_model(input op1_e op1, input op2_e op2, input word_t a,
                                      input word_t b);
    word_t r;
    r = '0;
    case (op1)
      OP1_ALUR: begin
        case (op2)
          OP2_EQ:   r = (a == b) ? 32'd1 : 32'd0;
          OP2_LT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          OP2_LE:   r = ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
          OP2_NE:   r = (a != b) ? 32'd1 : 32'd0;
          OP2_ADD:  r = a + b;
          OP2_AND:  r = a & b;
          OP2_OR:   r = a | b;
          OP2_XOR:  r = a ^ b;
          OP2_SUB:  r = a - b;
          OP2_NAND: r = ~(a & b);
          OP2_NOR:  r = ~(a | b);
          OP2_NXOR: r = ~(a ^ b);
          OP2_RSHF: r = word_t'($signed(a) >>> b[4:0]);  // Sign fills from the left
          OP2_LSHF: r = a << b[4:0];
          default:  r = '0;
        endcase
      end
      OP1_ADDI: r = a + b;
      OP1_ANDI: r = a & b;
      OP1_ORI:  r = a | b;
      OP1_XORI: r = a ^ b;
      default:  r = '0;
    endcase
    alu_model = r;
  endfunction

  function automatic logic branch_taken(input op1_e op1, input word_t a, input word_t b);
    case (op1)
      OP1_BEQ: branch_taken = (a == b);
      OP1_BLT: branch_taken = ($signed(a) < $signed(b));
      OP1_BLE: branch_taken = ($signed(a) <= $signed(b));
      default: branch_taken = (a != b);
    endcase
  endfunction

  // --------------------------------------------------
  // Program load, waits and checks
  // --------------------------------------------------
  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_hex(input hex_t expected, input string tag);
    if (hex !== expected) begin
      $display("MISMATCH at %0t ns: hex = 0x%h, expected 0x%h (%s)", $time, hex, expected, tag);
      stop_on_error();
    end
  endtask

  task automatic check_ledr(input ledr_t expected, input string tag);
    if (ledr !== expected) begin
      $display("MISMATCH at %0t ns: ledr = 0x%h, expected 0x%h (%s)", $time, ledr, expected,
               tag);
      stop_on_error();
    end
  endtask

  // Result to hex, then spin on BEQ r0,r0,-1
  task automatic push_hex_tail(input regno_t r);
    prog.push_back(enc_i(OP1_ADDI, 4'd4, 4'd0, HEX_ADDR[15:0]));
    prog.push_back(enc_i(OP1_SW, r, 4'd4, 16'h0000));
    prog.push_back(enc_i(OP1_BEQ, 4'd0, 4'd0, 16'hFFFF));
  endtask

  task automatic load_program();
    @(posedge clk);
    reset <= 1'b1;
    foreach (prog[i]) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= imem_addr_t'((`START_PC >> 2) + i);
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic wait_hex_store();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (hex === `HEX_RESET && cycles < WAIT_LIMIT) begin
      cycles++;
      @(negedge clk);
    end
    if (cycles >= WAIT_LIMIT) begin
      $display("Timeout at %0t ns: the program never stored a result to hex", $time);
      stop_on_error();
    end
  endtask

  task automatic run_program();
    load_program();
    wait_hex_store();
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_reset();
    prog.delete();
    prog.push_back(enc_i(OP1_BEQ, 4'd0, 4'd0, 16'hFFFF));
    load_program();
    @(negedge clk);
    check_hex(`HEX_RESET, "after reset");
    check_ledr('0, "after reset");
    repeat (10) @(negedge clk);   // Idle loop must leave the outputs alone
    check_hex(`HEX_RESET, "idle loop");
    check_ledr('0, "idle loop");
  endtask

  task automatic test_alu();
    logic [15:0] ia;
    logic [15:0] ib;
    foreach (alu_ops[k]) begin
      ia = 16'(rand_bits(16));
      if (alu_ops[k] inside {OP2_RSHF, OP2_LSHF}) begin
        ib = 16'(rand_bits(5));
      end else if (alu_ops[k] inside {OP2_EQ, OP2_LE, OP2_NE} && rand_bits(1) == 32'd1) begin
        ib = ia;   // Equal operands now and then
      end else begin
        ib = 16'(rand_bits(16));
      end
      prog.delete();
      prog.push_back(enc_i(OP1_ADDI, 4'd1, 4'd0, ia));
      prog.push_back(enc_i(OP1_ADDI, 4'd2, 4'd0, ib));
      prog.push_back(enc_r(alu_ops[k], 4'd3, 4'd1, 4'd2));
      push_hex_tail(4'd3);
      run_program();
      check_hex(hex_t'(alu_model(OP1_ALUR, alu_ops[k], sext(ia), sext(ib))), alu_ops[k].name());
    end
    foreach (imm_ops[k]) begin
      ia = 16'(rand_bits(16));
      ib = 16'(rand_bits(16));
      prog.delete();
      prog.push_back(enc_i(OP1_ADDI, 4'd1, 4'd0, ia));
      prog.push_back(enc_i(imm_ops[k], 4'd3, 4'd1, ib));
      push_hex_tail(4'd3);
      run_program();
      check_hex(hex_t'(alu_model(imm_ops[k], OP2_ADD, sext(ia), sext(ib))),
                imm_ops[k].name());
    end
  endtask

  task automatic test_hazards();
    logic [15:0] imm [4];
    word_t       s1;
    word_t       s2;
    word_t       s3;
    for (int n = 0; n < 3; n++) begin
      foreach (imm[i]) imm[i] = 16'(rand_bits(16));
      s1 = sext(imm[0]) + sext(imm[1]);
      s2 = s1 + sext(imm[2]);
      s3 = s1 + s2 - s1 + sext(imm[3]);
      prog.delete();
      prog.push_back(enc_i(OP1_ADDI, 4'd1, 4'd0, imm[0]));
      prog.push_back(enc_i(OP1_ADDI, 4'd1, 4'd1, imm[1]));
      prog.push_back(enc_i(OP1_ADDI, 4'd2, 4'd1, imm[2]));
      prog.push_back(enc_r(OP2_ADD, 4'd3, 4'd1, 4'd2));
      prog.push_back(enc_r(OP2_SUB, 4'd3, 4'd3, 4'd1));
      prog.push_back(enc_i(OP1_ADDI, 4'd3, 4'd3, imm[3]));
      prog.push_back(enc_r(OP2_ADD, 4'd6, 4'd3, 4'd2));
      push_hex_tail(4'd6);
      run_program();
      check_hex(hex_t'(s3 + s2), "dependent chain");
    end
  endtask

  task automatic test_memory();
    logic [15:0] v [3];
    foreach (v[i]) v[i] = 16'(rand_bits(16));
    prog.delete();
    for (int i = 0; i < 3; i++) begin
      prog.push_back(enc_i(OP1_ADDI, regno_t'(i + 1), 4'd0, v[i]));
    end
    for (int i = 0; i < 3; i++) begin
      prog.push_back(enc_i(OP1_SW, regno_t'(i + 1), 4'd0, 16'(16 + 4 * i)));
    end
    for (int i = 0; i < 3; i++) begin
      prog.push_back(enc_i(OP1_LW, regno_t'(i + 5), 4'd0, 16'(16 + 4 * i)));
    end
    prog.push_back(enc_r(OP2_ADD, 4'd8, 4'd5, 4'd6));
    prog.push_back(enc_r(OP2_XOR, 4'd8, 4'd8, 4'd7));
    prog.push_back(enc_i(OP1_ADDI, 4'd4, 4'd0, HEX_ADDR[15:0]));
    prog.push_back(enc_i(OP1_SW, 4'd3, 4'd4, LEDR_OFFSET[15:0]));   // LEDs before hex
    push_hex_tail(4'd8);
    run_program();
    check_hex(hex_t'((sext(v[0]) + sext(v[1])) ^ sext(v[2])), "load and combine");
    check_ledr(ledr_t'(v[2]), "store to ledr");
  endtask

  task automatic test_branches();
    logic taken;
    foreach (br_ops[k]) begin
      for (int p = 0; p < 3; p++) begin
        taken = branch_taken(br_ops[k], sext(br_a[p]), sext(br_b[p]));
        prog.delete();
        prog.push_back(enc_i(OP1_ADDI, 4'd1, 4'd0, br_a[p]));
        prog.push_back(enc_i(OP1_ADDI, 4'd2, 4'd0, br_b[p]));
        prog.push_back(enc_i(OP1_ADDI, 4'd5, 4'd0, 16'h0111));
        prog.push_back(enc_i(br_ops[k], 4'd2, 4'd1, 16'h0001));   // Skips one
        prog.push_back(enc_i(OP1_ADDI, 4'd5, 4'd0, 16'h0222));
        push_hex_tail(4'd5);
        run_program();
        check_hex(taken ? 24'h000111 : 24'h000222, br_ops[k].name());
      end
    end
  endtask

  task automatic test_jal_keys();
    word_t jal_addr;
    key_t  key_val;
    jal_addr = `START_PC + 32'd4;
    prog.delete();
    prog.push_back(enc_i(OP1_ADDI, 4'd1, 4'd0, 16'(`START_PC)));
    prog.push_back(enc_i(OP1_JAL, 4'd9, 4'd1, 16'h0004));          // To START_PC + 16
    prog.push_back(enc_i(OP1_ADDI, 4'd9, 4'd0, 16'h0077));         // Flushed
    prog.push_back(enc_i(OP1_BEQ, 4'd0, 4'd0, 16'hFFFF));
    push_hex_tail(4'd9);
    run_program();
    check_hex(hex_t'(jal_addr + 32'd4), "JAL link");

    key_val = key_t'(rand_bits(4));
    @(posedge clk);
    key <= key_val;
    prog.delete();
    prog.push_back(enc_i(OP1_ADDI, 4'd4, 4'd0, HEX_ADDR[15:0]));
    prog.push_back(enc_i(OP1_LW, 4'd5, 4'd4, KEY_OFFSET[15:0]));
    push_hex_tail(4'd5);
    run_program();
    check_hex({{(`HEX_BITS-`KEY_BITS){1'b0}}, ~key_val}, "key read");
  endtask

  initial begin
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    key       = '1;   // No key pressed
    test_reset();
    test_alu();
    test_hazards();
    test_memory();
    test_branches();
    test_jal_keys();
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --assert --top-module tb_cpu -f tb.f -o tb_cpu_sim

# The log decides pass or fail
./obj_dir/tb_cpu_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Done: no errors" sim.log
echo "Simulation passed"
